/* logic/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ----------------------------------------
// Sizes of the load/store unit
// ----------------------------------------

// Word width in bits
`define LSU_DATA_BITS 32

// Data RAM depth in words
`define LSU_MEM_WORDS 256

// Byte address width, word address is the upper part
`define LSU_ADDR_BITS 10

`endif

/* logic/lsu_pkg.sv */
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    // ----------------------------------------
    // Data word
    // ----------------------------------------
    typedef logic [`LSU_DATA_BITS-1:0] word_t;

    // ----------------------------------------
    // Memory opcodes
    // ----------------------------------------
    typedef enum logic [3:0] {
        NOP,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } mem_op_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } lsu_state_t;

endpackage

`default_nettype wire

/* logic/lsu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_ctrl import lsu_pkg::*; (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        req,
        input  mem_op_t                     op,
        input  logic [`LSU_ADDR_BITS-1:0]   addr,
        input  word_t                       wdata,
        input  word_t                       reg_dataC,
        output logic                        busy,
        output logic                        done,
        output logic                        error,
        output mem_op_t                     cur_op,
        output logic [1:0]                  byte_off,
        output logic [`LSU_ADDR_BITS-3:0]   word_addr,
        output word_t                       store_data,
        output word_t                       merge_data,
        output logic                        ram_en,
        output logic                        ram_we
    );

    lsu_state_t                  state;
    lsu_state_t                  next_state;
    logic [`LSU_ADDR_BITS-1:0]   addr_q;
    logic                        misaligned_q;
    logic                        accept;

    // Halfword needs bit 0 clear, word needs both low bits clear
    function automatic logic is_misaligned(input mem_op_t o, input logic [1:0] off);
        case (o)
            LH, LHU, SH: is_misaligned = off[0];
            LW, SW:      is_misaligned = (off != 2'b00);
            default:     is_misaligned = 1'b0;
        endcase
    endfunction

    function automatic logic is_load(input mem_op_t o);
        case (o)
            LB, LBU, LH, LHU, LW, LWL, LWR: is_load = 1'b1;
            default:                        is_load = 1'b0;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_t o);
        case (o)
            SB, SH, SW, SWL, SWR: is_store = 1'b1;
            default:              is_store = 1'b0;
        endcase
    endfunction

    assign accept = (state == IDLE) && req;

    // ----------------------------------------
    // State register and next state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            IDLE:    next_state = req ? ACCESS : IDLE;
            ACCESS:  next_state = RESPOND;
            RESPOND: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Operand capture on an accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_op       <= op;
            addr_q       <= addr;
            store_data   <= wdata;
            merge_data   <= reg_dataC;
            misaligned_q <= is_misaligned(op, addr[1:0]);
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign busy  = (state != IDLE);
    assign done  = (state == RESPOND);
    assign error = (state == RESPOND) && misaligned_q;

    // NOP and refused ops never reach the RAM
    assign ram_en = (state == ACCESS) && !misaligned_q
                    && (is_load(cur_op) || is_store(cur_op));
    assign ram_we = (state == ACCESS) && !misaligned_q && is_store(cur_op);

    assign byte_off  = addr_q[1:0];
    assign word_addr = addr_q[`LSU_ADDR_BITS-1:2];

endmodule

`default_nettype wire

/* logic/store_format.sv */
`timescale 1ns/1ps
`default_nettype none

module store_format import lsu_pkg::*; (
        input  mem_op_t     op,
        input  logic [1:0]  byte_off,
        input  word_t       store_data,
        output word_t       store_word,
        output logic [3:0]  store_be
    );

    logic [4:0] lane_shift;
    logic [4:0] left_shift;

    // Bit offset of the addressed lane, and of the lanes above it
    assign lane_shift = {byte_off, 3'b000};
    assign left_shift = {~byte_off, 3'b000};

    always_comb begin
        case (op)
            SB: begin
                store_word = {4{store_data[7:0]}};
                store_be   = 4'b0001 << byte_off;
            end
            SH: begin
                store_word = {2{store_data[15:0]}};
                store_be   = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                store_word = store_data;
                store_be   = 4'b1111;
            end
            // Top bytes of rt land in bytes 0 to k
            SWL: begin
                store_word = store_data >> left_shift;
                store_be   = 4'b1111 >> (2'd3 - byte_off);
            end
            // Low bytes of rt land in bytes k to 3
            SWR: begin
                store_word = store_data << lane_shift;
                store_be   = 4'b1111 << byte_off;
            end
            default: begin
                store_word = store_data;
                store_be   = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/readdata_format.sv */
`timescale 1ns/1ps
`default_nettype none

module readdata_format import lsu_pkg::*; (
        input  word_t       _rd,
        input  logic [1:0]  addr,
        input  mem_op_t     op,
        input  word_t       reg_dataC,
        output word_t       rd
    );

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [4:0]  lane_shift;
    logic [4:0]  left_shift;
    word_t       lwl_mask;
    word_t       lwr_mask;

    // ----------------------------------------
    // Lane selection
    // ----------------------------------------
    assign lane_shift = {addr, 3'b000};
    assign left_shift = {~addr, 3'b000};

    assign sel_byte = _rd[lane_shift +: 8];
    assign sel_half = addr[1] ? _rd[31:16] : _rd[15:0];

    // Bits taken from memory for the unaligned merges
    assign lwl_mask = {`LSU_DATA_BITS{1'b1}} << left_shift;
    assign lwr_mask = {`LSU_DATA_BITS{1'b1}} >> lane_shift;

    // ----------------------------------------
    // Result formatting
    // ----------------------------------------
    always_comb begin
        case (op)
            LB: begin
                rd = {{24{sel_byte[7]}}, sel_byte};
            end
            LBU: begin
                rd = {24'b0, sel_byte};
            end
            LH: begin
                rd = {{16{sel_half[15]}}, sel_half};
            end
            LHU: begin
                rd = {16'b0, sel_half};
            end
            // Bytes 0..k go to the top, low part kept from rt
            LWL: begin
                rd = (_rd << left_shift) | (reg_dataC & ~lwl_mask);
            end
            // Bytes k..3 go to the bottom, top part kept from rt
            LWR: begin
                rd = (_rd >> lane_shift) | (reg_dataC & ~lwr_mask);
            end
            default: begin
                rd = _rd;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module data_ram import lsu_pkg::*; (
        input  logic                        clk,
        input  logic                        en,
        input  logic                        we,
        input  logic [`LSU_ADDR_BITS-3:0]   word_addr,
        input  logic [3:0]                  be,
        input  word_t                       wdata,
        output word_t                       rdata
    );

    word_t mem [`LSU_MEM_WORDS];

    // Byte lane writes, read returns the old word
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < `LSU_DATA_BITS / 8; i++) begin
                    if (be[i]) begin
                        mem[word_addr][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
            rdata <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_top import lsu_pkg::*; (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        req,
        input  mem_op_t                     op,
        input  logic [`LSU_ADDR_BITS-1:0]   addr,
        input  word_t                       wdata,
        input  word_t                       reg_dataC,
        output logic                        busy,
        output logic                        done,
        output logic                        error,
        output word_t                       rdata
    );

    mem_op_t                     cur_op;
    logic [1:0]                  byte_off;
    logic [`LSU_ADDR_BITS-3:0]   word_addr;
    word_t                       store_data;
    word_t                       merge_data;
    logic                        ram_en;
    logic                        ram_we;
    word_t                       store_word;
    logic [3:0]                  store_be;
    word_t                       ram_rdata;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    lsu_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .reg_dataC  (reg_dataC),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .cur_op     (cur_op),
        .byte_off   (byte_off),
        .word_addr  (word_addr),
        .store_data (store_data),
        .merge_data (merge_data),
        .ram_en     (ram_en),
        .ram_we     (ram_we)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    store_format u_store_format (
        .op         (cur_op),
        .byte_off   (byte_off),
        .store_data (store_data),
        .store_word (store_word),
        .store_be   (store_be)
    );

    data_ram u_data_ram (
        .clk        (clk),
        .en         (ram_en),
        .we         (ram_we),
        .word_addr  (word_addr),
        .be         (store_be),
        .wdata      (store_word),
        .rdata      (ram_rdata)
    );

    readdata_format u_readdata_format (
        ._rd        (ram_rdata),
        .addr       (byte_off),
        .op         (cur_op),
        .reg_dataC  (merge_data),
        .rd         (rdata)
    );

endmodule

`default_nettype wire

/* verif/lsu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
        input logic clk,
        input logic reset,
        input logic req,
        input logic busy,
        input logic done,
        input logic error,
        input logic ram_we
    );

    // Done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

    // Accepted request completes two edges later
    assert property (@(posedge clk) disable iff (reset) (req && !busy) |-> ##2 done)
        else $error("done did not follow an accepted req after two cycles");

    // Refused ops never write
    assert property (@(posedge clk) disable iff (reset) error |-> !$past(ram_we))
        else $error("ram_we high during an op that ended with error");

    assert property (@(posedge clk) reset |=> !busy)
        else $error("busy high after reset");

endmodule

bind lsu_ctrl lsu_assertions u_lsu_assertions (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .error  (error),
    .ram_we (ram_we)
);

`default_nettype wire

/* verif/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

    // Room for about 500 ops of three cycles each, with margin
    localparam int OP_BUDGET  = 500;
    localparam int MAX_CYCLES = 8 * OP_BUDGET;

    logic                      clk;
    logic                      reset;
    logic                      req;
    mem_op_t                   op;
    logic [`LSU_ADDR_BITS-1:0] addr;
    word_t                     wdata;
    word_t                     reg_dataC;
    logic                      busy;
    logic                      done;
    logic                      error;
    word_t                     rdata;

    // Byte-wide reference memory
    logic [7:0]  mem_model [4*`LSU_MEM_WORDS];
    int          cycle_count;
    int          err_count;
    int          check_count;
    int          test_count;
    int          errs_before;
    int unsigned seed;

    lsu_top UUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .reg_dataC (reg_dataC),
        .busy      (busy),
        .done      (done),
        .error     (error),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic misaligned(input mem_op_t o, input logic [9:0] a);
        case (o)
            LH, LHU, SH: misaligned = a[0];
            LW, SW:      misaligned = (a[1:0] != 2'b00);
            default:     misaligned = 1'b0;
        endcase
    endfunction

    function automatic logic load_op(input mem_op_t o);
        load_op = (o inside {LB, LBU, LH, LHU, LW, LWL, LWR});
    endfunction

    function automatic logic store_op(input mem_op_t o);
        store_op = (o inside {SB, SH, SW, SWL, SWR});
    endfunction

    function automatic word_t predict_load(input mem_op_t o, input logic [9:0] a,
                                           input word_t regc);
        int    k;
        word_t w;
        word_t r;
        k = a[1:0];
        for (int i = 0; i < 4; i++) begin
            w[i*8 +: 8] = mem_model[{a[9:2], 2'b00} + i];
        end
        r = regc;
        case (o)
            LB:  r = {{24{w[k*8+7]}}, w[k*8 +: 8]};
            LBU: r = {24'h0, w[k*8 +: 8]};
            LH:  r = {{16{w[k*8+15]}}, w[k*8 +: 16]};
            LHU: r = {16'h0, w[k*8 +: 16]};
            // Bytes 0..k fill the top of the result
            LWL: for (int j = 0; j <= k; j++) r[(3-k+j)*8 +: 8] = w[j*8 +: 8];
            LWR: for (int j = k; j < 4; j++) r[(j-k)*8 +: 8] = w[j*8 +: 8];
            default: r = w;
        endcase
        return r;
    endfunction

    function automatic void update_model(input mem_op_t o, input logic [9:0] a, input word_t rt);
        int         k;
        logic [9:0] base;
        k = a[1:0];
        base = {a[9:2], 2'b00};
        case (o)
            SB: mem_model[a] = rt[7:0];
            SH: {mem_model[a+1], mem_model[a]} = rt[15:0];
            SW: for (int j = 0; j < 4; j++) mem_model[base+j] = rt[j*8 +: 8];
            SWL: for (int j = 0; j <= k; j++) mem_model[base+j] = rt[(3-k+j)*8 +: 8];
            SWR: for (int j = k; j < 4; j++) mem_model[base+j] = rt[(j-k)*8 +: 8];
            default: ;
        endcase
    endfunction

    // ----------------------------------------
    // Driving and checking
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s: %0d errors", name, err_count - errs_before);
        errs_before = err_count;
    endtask

    task automatic do_op(input mem_op_t o, input logic [9:0] a, input word_t rt,
                         input word_t regc, output word_t result, output logic err);
        int waited;
        @(negedge clk);
        req = 1'b1;
        op = o;
        addr = a;
        wdata = rt;
        reg_dataC = regc;
        @(negedge clk);
        req = 1'b0;
        waited = 1;
        while (!done) begin
            @(negedge clk);
            waited++;
        end
        result = rdata;
        err = error;
        check_value("done latency", waited, 2);
    endtask

    task automatic exec_and_check(input mem_op_t o, input logic [9:0] a, input word_t rt,
                                  input word_t regc);
        word_t got;
        word_t expected;
        logic  err;
        logic  exp_err;
        exp_err = misaligned(o, a);
        expected = predict_load(o, a, regc);
        do_op(o, a, rt, regc, got, err);
        check_value("error", err, exp_err);
        if (!exp_err && load_op(o)) begin
            check_value("rdata", got, expected);
        end
        if (!exp_err && store_op(o)) begin
            update_model(o, a, rt);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic word_round_trip();
        for (int i = 0; i < 5; i++) begin
            exec_and_check(SW, i * 10'h0fc, $urandom, 0);
        end
        for (int i = 0; i < 5; i++) begin
            exec_and_check(LW, i * 10'h0fc, 0, 0);
        end
        end_test("word access");
    endtask

    task automatic extension_loads();
        exec_and_check(SW, 10'h100, 32'hf08a_c3ff, 0);
        exec_and_check(SW, 10'h104, 32'h8001_7ffe, 0);
        for (int a = 10'h100; a < 10'h108; a++) begin
            exec_and_check(LB, a, 0, 0);
            exec_and_check(LBU, a, 0, 0);
            if (a % 2 == 0) begin
                exec_and_check(LH, a, 0, 0);
                exec_and_check(LHU, a, 0, 0);
            end
        end
        end_test("sign and zero extension");
    endtask

    task automatic partial_stores();
        for (int k = 0; k < 4; k++) begin
            exec_and_check(SW, 10'h120, 32'h1122_3344, 0);
            exec_and_check(SB, 10'h120 + k, 32'h0000_00a0 + k, 0);
            exec_and_check(LW, 10'h120, 0, 0);
        end
        for (int k = 0; k < 4; k += 2) begin
            exec_and_check(SW, 10'h124, 32'h5566_7788, 0);
            exec_and_check(SH, 10'h124 + k, 32'h9999_beef, 0);
            exec_and_check(LW, 10'h124, 0, 0);
        end
        end_test("byte and half stores");
    endtask

    task automatic unaligned_merges();
        for (int k = 0; k < 4; k++) begin
            exec_and_check(SW, 10'h140, 32'h8899_aabb, 0);
            exec_and_check(LWL, 10'h140 + k, 0, $urandom);
            exec_and_check(LWR, 10'h140 + k, 0, $urandom);
            exec_and_check(SW, 10'h144, 32'h0102_0304, 0);
            exec_and_check(SWL, 10'h144 + k, $urandom, 0);
            exec_and_check(LW, 10'h144, 0, 0);
            exec_and_check(SW, 10'h148, 32'h0506_0708, 0);
            exec_and_check(SWR, 10'h148 + k, $urandom, 0);
            exec_and_check(LW, 10'h148, 0, 0);
        end
        end_test("unaligned merges");
    endtask

    task automatic misaligned_and_busy();
        exec_and_check(SW, 10'h160, 32'hcafe_f00d, 0);
        exec_and_check(SW, 10'h164, 32'h5555_aaaa, 0);
        exec_and_check(LH, 10'h161, 0, 0);
        exec_and_check(LHU, 10'h163, 0, 0);
        exec_and_check(LW, 10'h162, 0, 0);
        exec_and_check(SH, 10'h161, 32'h1234_5678, 0);
        exec_and_check(SW, 10'h163, 32'h1234_5678, 0);
        exec_and_check(LW, 10'h160, 0, 0);
        // Req held through ACCESS and RESPOND must be dropped
        @(negedge clk);
        req = 1'b1;
        op = SW;
        addr = 10'h160;
        wdata = 32'h0bad_cafe;
        @(negedge clk);
        check_value("busy", busy, 1'b1);
        addr = 10'h164;
        wdata = 32'hdead_beef;
        @(negedge clk);
        check_value("done", done, 1'b1);
        @(negedge clk);
        req = 1'b0;
        check_value("busy", busy, 1'b0);
        update_model(SW, 10'h160, 32'h0bad_cafe);
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        exec_and_check(LW, 10'h160, 0, 0);
        exec_and_check(LW, 10'h164, 0, 0);
        end_test("misaligned and busy");
    endtask

    task automatic random_mix();
        mem_op_t o;
        // Fill the low 64 words so every random load sees known data
        for (int w = 0; w < 64; w++) begin
            exec_and_check(SW, w * 4, 32'h8080_8080 ^ {w[7:0], ~w[7:0], w[7:0] ^ 8'h3c, 8'h11}, 0);
        end
        for (int n = 0; n < 200; n++) begin
            o = mem_op_t'($urandom_range(12, 0));
            exec_and_check(o, $urandom_range(255, 0), $urandom, $urandom);
        end
        end_test("random mix");
    endtask

    initial begin
        seed = $urandom(32'hbd0b_0f40);
        reset = 1'b1;
        req = 1'b0;
        op = NOP;
        addr = '0;
        wdata = '0;
        reg_dataC = '0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        errs_before = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        word_round_trip();
        extension_loads();
        partial_stores();
        unaligned_merges();
        misaligned_and_busy();
        random_mix();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_ctrl.sv
logic/store_format.sv
logic/readdata_format.sv
logic/data_ram.sv
logic/lsu_top.sv
verif/lsu_assertions.sv
verif/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_ctrl.sv
      - logic/store_format.sv
      - logic/readdata_format.sv
      - logic/data_ram.sv
      - logic/lsu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/lsu_assertions.sv
      - verif/lsu_tb.sv
